/* include/dct_config.svh */
`ifndef DCT_CONFIG_SVH
`define DCT_CONFIG_SVH

// points per block
`define DCT_N 8

// input samples
`define DCT_SAMPLE_W 22

// butterfly sums and differences, one bit of growth
`define DCT_PAIR_W 23

// products and accumulators
`define DCT_ACC_W 24

// output coefficients
`define DCT_COEF_W 22

// final divide by four
`define DCT_OUT_SHIFT 2

`endif

/* verilog/dct_types_pkg.sv */
`default_nettype none

`include "dct_config.svh"

package dct_types_pkg;

	// raw input word
	typedef logic signed [`DCT_SAMPLE_W-1:0] sample_t;

	// butterfly output, one bit wider than a sample
	typedef logic signed [`DCT_PAIR_W-1:0] pair_t;

	// shift-add product and running sum
	typedef logic signed [`DCT_ACC_W-1:0] prod_t;

	// scaled result
	typedef logic signed [`DCT_COEF_W-1:0] coef_t;

endpackage

`default_nettype wire

/* verilog/dct_ctrl_pkg.sv */
`default_nettype none

`include "dct_config.svh"

package dct_ctrl_pkg;

	// sample position in a block, also the coefficient number
	typedef logic [$clog2(`DCT_N)-1:0] sample_idx_t;

	// pair j holds x(j) and x(N-1-j)
	typedef logic [$clog2(`DCT_N/2)-1:0] pair_idx_t;

	typedef enum logic [1:0] {
		IDLE,
		ACCUMULATE,
		DRAIN
	} mac_state_t;

endpackage

`default_nettype wire

/* verilog/dct_butterfly.sv */
`default_nettype none

`include "dct_config.svh"

module dct_butterfly
	import dct_types_pkg::*;
	import dct_ctrl_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    in_valid,
	input  wire sample_t in_sample,
	output logic         pair_valid,
	output pair_t        pair_sum,
	output pair_t        pair_diff
);

	localparam int HALF = `DCT_N / 2;

	sample_idx_t idx;
	sample_t     stack [HALF];
	sample_t     top;
	logic        second_half;

	assign top = stack[0];
	assign second_half = (idx >= sample_idx_t'(HALF));

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			idx <= '0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= in_valid && second_half;
			if (in_valid)
				idx <= idx + 1'b1;
		end
	end

	// first half pushes, second half pops the mirrored sample
	always_ff @(posedge clk) begin
		if (in_valid) begin
			if (second_half) begin
				pair_sum <= pair_t'(top) + pair_t'(in_sample);
				pair_diff <= pair_t'(top) - pair_t'(in_sample);
				for (int i = 0; i < HALF - 1; i++)
					stack[i] <= stack[i + 1];
			end else begin
				stack[0] <= in_sample;
				for (int i = 1; i < HALF; i++)
					stack[i] <= stack[i - 1];
			end
		end
	end

	// no unknown samples on valid cycles
	a_known_sample: assert property (
		@(posedge clk) disable iff (!rst)
		in_valid |-> !$isunknown(in_sample)
	);

endmodule

`default_nettype wire

/* verilog/dct_pair_buffer.sv */
`default_nettype none

`include "dct_config.svh"

module dct_pair_buffer
	import dct_types_pkg::*;
	import dct_ctrl_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  pair_valid,
	input  wire pair_t pair_sum,
	input  wire pair_t pair_diff,
	output logic       blk_start,
	output pair_t      blk_sum,
	output pair_t      blk_diff
);

	localparam int DEPTH = `DCT_N / 2;

	pair_t     sum_mem  [2][DEPTH];
	pair_t     diff_mem [2][DEPTH];
	logic      wr_bank;
	logic      rd_bank;
	logic      rd_active;
	pair_idx_t wr_cnt;
	pair_idx_t rd_cnt;
	pair_idx_t wr_addr;

	// pairs arrive innermost first, so fill from the top
	assign wr_addr = pair_idx_t'(DEPTH - 1) - wr_cnt;

	assign blk_sum = sum_mem[rd_bank][rd_cnt];
	assign blk_diff = diff_mem[rd_bank][rd_cnt];

	always_ff @(posedge clk) begin
		if (pair_valid) begin
			sum_mem[wr_bank][wr_addr] <= pair_sum;
			diff_mem[wr_bank][wr_addr] <= pair_diff;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_bank <= 1'b0;
			rd_bank <= 1'b0;
			rd_active <= 1'b0;
			wr_cnt <= '0;
			rd_cnt <= '0;
			blk_start <= 1'b0;
		end else begin
			blk_start <= 1'b0;
			if (rd_active) begin
				rd_cnt <= rd_cnt + 1'b1;
				if (rd_cnt == pair_idx_t'(DEPTH - 1))
					rd_active <= 1'b0;
			end
			if (pair_valid) begin
				wr_cnt <= wr_cnt + 1'b1;
				// full bank goes to the consumer
				if (wr_cnt == pair_idx_t'(DEPTH - 1)) begin
					wr_bank <= ~wr_bank;
					rd_bank <= wr_bank;
					rd_active <= 1'b1;
					rd_cnt <= '0;
					blk_start <= 1'b1;
				end
			end
		end
	end

	// replay ends before the other bank fills
	a_no_overwrite: assert property (
		@(posedge clk) disable iff (!rst)
		pair_valid && rd_active |-> wr_cnt != pair_idx_t'(DEPTH - 1)
	);

endmodule

`default_nettype wire

/* verilog/dct_even_odd_mac.sv */
`default_nettype none

`include "dct_config.svh"

module dct_even_odd_mac
	import dct_types_pkg::*;
	import dct_ctrl_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst,
	input  wire logic  blk_start,
	input  wire pair_t blk_sum,
	input  wire pair_t blk_diff,
	output logic       out_valid,
	output sample_idx_t out_index,
	output coef_t      out_coef
);

	prod_t       mul_a;
	prod_t       mul_c;
	prod_t       mul_f;
	prod_t       mul_b;
	prod_t       mul_d;
	prod_t       mul_e;
	prod_t       mul_g;
	prod_t       acc [`DCT_N];
	coef_t       res [`DCT_N];
	mac_state_t  state;
	pair_idx_t   acc_idx;
	sample_idx_t out_cnt;
	logic        out_busy;

	// each term truncated on its own
	function automatic prod_t sra(pair_t x, int unsigned n);
		return prod_t'(x >>> n);
	endfunction

	// even constants from sums, odd constants from differences
	always_ff @(posedge clk) begin
		mul_a <= sra(blk_sum, 2) + sra(blk_sum, 4) + sra(blk_sum, 5) + sra(blk_sum, 7)
			+ sra(blk_sum, 9);
		mul_c <= sra(blk_sum, 1) - sra(blk_sum, 5) - sra(blk_sum, 7) + sra(blk_sum, 10);
		mul_f <= sra(blk_sum, 3) + sra(blk_sum, 4) + sra(blk_sum, 8) - sra(blk_sum, 14);
		mul_b <= sra(blk_diff, 1) - sra(blk_diff, 7) - sra(blk_diff, 9) + sra(blk_diff, 13);
		mul_d <= sra(blk_diff, 2) + sra(blk_diff, 3) + sra(blk_diff, 5) + sra(blk_diff, 7)
			+ sra(blk_diff, 9) - sra(blk_diff, 12);
		mul_e <= sra(blk_diff, 2) + sra(blk_diff, 5) - sra(blk_diff, 8) + sra(blk_diff, 11);
		mul_g <= sra(blk_diff, 4) + sra(blk_diff, 5) + sra(blk_diff, 8) - sra(blk_diff, 13);
	end

	// signs of cos((2j+1)k*pi/16) per pair j
	always_ff @(posedge clk) begin
		if (blk_start) begin
			for (int k = 0; k < `DCT_N; k++)
				acc[k] <= '0;
		end else if (state == ACCUMULATE) begin
			case (acc_idx)
				2'd0: begin
					acc[0] <= acc[0] + mul_a;
					acc[2] <= acc[2] + mul_c;
					acc[4] <= acc[4] + mul_a;
					acc[6] <= acc[6] + mul_f;
					acc[1] <= acc[1] + mul_b;
					acc[3] <= acc[3] + mul_d;
					acc[5] <= acc[5] + mul_e;
					acc[7] <= acc[7] + mul_g;
				end
				2'd1: begin
					acc[0] <= acc[0] + mul_a;
					acc[2] <= acc[2] + mul_f;
					acc[4] <= acc[4] - mul_a;
					acc[6] <= acc[6] - mul_c;
					acc[1] <= acc[1] + mul_d;
					acc[3] <= acc[3] - mul_g;
					acc[5] <= acc[5] - mul_b;
					acc[7] <= acc[7] - mul_e;
				end
				2'd2: begin
					acc[0] <= acc[0] + mul_a;
					acc[2] <= acc[2] - mul_f;
					acc[4] <= acc[4] - mul_a;
					acc[6] <= acc[6] + mul_c;
					acc[1] <= acc[1] + mul_e;
					acc[3] <= acc[3] - mul_b;
					acc[5] <= acc[5] + mul_g;
					acc[7] <= acc[7] + mul_d;
				end
				default: begin
					acc[0] <= acc[0] + mul_a;
					acc[2] <= acc[2] - mul_c;
					acc[4] <= acc[4] + mul_a;
					acc[6] <= acc[6] - mul_f;
					acc[1] <= acc[1] + mul_g;
					acc[3] <= acc[3] - mul_e;
					acc[5] <= acc[5] + mul_d;
					acc[7] <= acc[7] - mul_b;
				end
			endcase
		end
	end

	// results park here so the next block can accumulate while these drain
	always_ff @(posedge clk) begin
		if (state == DRAIN) begin
			for (int k = 0; k < `DCT_N; k++)
				res[k] <= coef_t'(acc[k] >>> `DCT_OUT_SHIFT);
		end
		if (out_busy)
			out_coef <= res[out_cnt];
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
			acc_idx <= '0;
			out_busy <= 1'b0;
			out_cnt <= '0;
			out_valid <= 1'b0;
			out_index <= '0;
		end else begin
			out_valid <= out_busy;
			if (out_busy) begin
				out_index <= out_cnt;
				out_cnt <= out_cnt + 1'b1;
				if (out_cnt == sample_idx_t'(`DCT_N - 1))
					out_busy <= 1'b0;
			end
			case (state)
				IDLE: begin
					if (blk_start) begin
						state <= ACCUMULATE;
						acc_idx <= '0;
					end
				end
				ACCUMULATE: begin
					acc_idx <= acc_idx + 1'b1;
					if (acc_idx == pair_idx_t'(`DCT_N / 2 - 1))
						state <= DRAIN;
				end
				DRAIN: begin
					// restart the output count, overrides the finishing drain
					out_busy <= 1'b1;
					out_cnt <= '0;
					state <= blk_start ? ACCUMULATE : IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_no_early_block: assert property (
		@(posedge clk) disable iff (!rst)
		state == ACCUMULATE |-> !blk_start
	);

endmodule

`default_nettype wire

/* verilog/dct_1d_top.sv */
`default_nettype none

module dct_1d_top
	import dct_types_pkg::*;
	import dct_ctrl_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rst,
	input  wire logic    in_valid,
	input  wire sample_t in_sample,
	output logic         out_valid,
	output sample_idx_t  out_index,
	output coef_t        out_coef
);

	logic  pair_valid;
	pair_t pair_sum;
	pair_t pair_diff;
	logic  blk_start;
	pair_t blk_sum;
	pair_t blk_diff;

	dct_butterfly i_butterfly (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_sample  (in_sample),
		.pair_valid (pair_valid),
		.pair_sum   (pair_sum),
		.pair_diff  (pair_diff)
	);

	dct_pair_buffer i_pair_buffer (
		.clk        (clk),
		.rst        (rst),
		.pair_valid (pair_valid),
		.pair_sum   (pair_sum),
		.pair_diff  (pair_diff),
		.blk_start  (blk_start),
		.blk_sum    (blk_sum),
		.blk_diff   (blk_diff)
	);

	dct_even_odd_mac i_mac (
		.clk        (clk),
		.rst        (rst),
		.blk_start  (blk_start),
		.blk_sum    (blk_sum),
		.blk_diff   (blk_diff),
		.out_valid  (out_valid),
		.out_index  (out_index),
		.out_coef   (out_coef)
	);

endmodule

`default_nettype wire

/* sim/dct_checker.sv */
`default_nettype none

`include "dct_config.svh"

module dct_checker
	import dct_types_pkg::*;
(
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic                      in_valid,
	input  wire sample_t                   in_sample,
	input  wire logic                      out_valid,
	input  wire logic [$clog2(`DCT_N)-1:0] out_index,
	input  wire coef_t                     out_coef,
	output int                             error_count,
	output int                             check_count,
	output int                             pending
);

	timeunit 1ns;
	timeprecision 1ps;

	// x7 is captured on the edge after its sample point, X0 lands 8 edges later
	localparam int LATENCY = 9;

	int    blk [`DCT_N];
	int    fill;
	int    cycle;
	int    due_q [$];
	int    idx_q [$];
	coef_t coef_q [$];

	// shift list per cosine, minus means subtract, zero ends the list
	function automatic prod_t scale(int x, int m);
		int    terms [6];
		prod_t sum;
		case (m)
			0, 4: terms = '{2, 4, 5, 7, 9, 0};
			1: terms = '{1, -7, -9, 13, 0, 0};
			2: terms = '{1, -5, -7, 10, 0, 0};
			3: terms = '{2, 3, 5, 7, 9, -12};
			5: terms = '{2, 5, -8, 11, 0, 0};
			6: terms = '{3, 4, 8, -14, 0, 0};
			default: terms = '{4, 5, 8, -13, 0, 0};
		endcase
		sum = '0;
		foreach (terms[i]) begin
			if (terms[i] > 0)
				sum = sum + prod_t'(x >>> terms[i]);
			else if (terms[i] < 0)
				sum = sum - prod_t'(x >>> -terms[i]);
		end
		return sum;
	endfunction

	function automatic coef_t expected_coef(int x [`DCT_N], int k);
		prod_t acc;
		int    p;
		int    m;
		int    v;
		acc = '0;
		for (int j = 0; j < `DCT_N / 2; j++) begin
			v = (k % 2 == 0) ? x[j] + x[`DCT_N - 1 - j] : x[j] - x[`DCT_N - 1 - j];
			// angle in units of pi/16, folded into the first quadrant
			p = ((2 * j + 1) * k) % 32;
			if (p <= 8)
				acc = acc + scale(v, p);
			else if (p <= 16)
				acc = acc - scale(v, 16 - p);
			else if (p <= 24)
				acc = acc - scale(v, p - 16);
			else
				acc = acc + scale(v, 32 - p);
		end
		return coef_t'(acc >>> `DCT_OUT_SHIFT);
	endfunction

	task automatic report_mismatch(string name, logic signed [31:0] exp,
		logic signed [31:0] got);
		error_count++;
		$display("ERROR at %0d ns: %s expected %0d, got %0d", $time, name, exp, got);
	endtask

	initial begin
		error_count = 0;
		check_count = 0;
		pending = 0;
		fill = 0;
		cycle = 0;
	end

	always @(negedge clk) begin
		cycle++;
		if (!rst) begin
			// partial block and queued results are lost
			fill = 0;
			due_q.delete();
			idx_q.delete();
			coef_q.delete();
			if (out_valid !== 1'b0)
				report_mismatch("out_valid", 0, out_valid);
		end else begin
			if (due_q.size() > 0 && due_q[0] == cycle) begin
				if (out_valid !== 1'b1)
					report_mismatch("out_valid", 1, out_valid);
				if (out_index !== idx_q[0])
					report_mismatch("out_index", idx_q[0], out_index);
				if (out_coef !== coef_q[0])
					report_mismatch("out_coef", coef_q[0], out_coef);
				check_count++;
				void'(due_q.pop_front());
				void'(idx_q.pop_front());
				void'(coef_q.pop_front());
			end else if (out_valid !== 1'b0) begin
				report_mismatch("out_valid", 0, out_valid);
			end
			if (in_valid === 1'b1) begin
				blk[fill] = in_sample;
				fill++;
				if (fill == `DCT_N) begin
					for (int k = 0; k < `DCT_N; k++) begin
						due_q.push_back(cycle + LATENCY + k);
						idx_q.push_back(k);
						coef_q.push_back(expected_coef(blk, k));
					end
					fill = 0;
				end
			end
		end
		pending = due_q.size();
	end

endmodule

`default_nettype wire

/* sim/tb_dct_1d.sv */
`default_nettype none

`include "dct_config.svh"

module tb_dct_1d
	import dct_types_pkg::*;
	import dct_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD = 20;
	localparam int DRIVE_DLY = 1;
	localparam int unsigned SEED = 32'hce798a11;
	localparam int NUM_CONST = 4;
	localparam int NUM_DENSE = 24;
	localparam int NUM_GAPPY = 16;
	localparam int NUM_AFTER_RST = 4;
	// full blocks plus the one cut by reset
	localparam int NUM_BLOCKS = NUM_CONST + NUM_DENSE + NUM_GAPPY + NUM_AFTER_RST + 1;
	localparam int EXPECTED = (NUM_BLOCKS - 1) * `DCT_N;
	localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 40 + 200;
	localparam sample_t MAX_SAMPLE = sample_t'((1 << (`DCT_SAMPLE_W - 1)) - 1);
	localparam sample_t MIN_SAMPLE = sample_t'(1 << (`DCT_SAMPLE_W - 1));

	logic        clk;
	logic        rst;
	logic        in_valid;
	sample_t     in_sample;
	logic        out_valid;
	sample_idx_t out_index;
	coef_t       out_coef;
	int          error_count;
	int          check_count;
	int          pending;

	dct_1d_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.out_valid (out_valid),
		.out_index (out_index),
		.out_coef  (out_coef)
	);

	dct_checker i_checker (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_sample   (in_sample),
		.out_valid   (out_valid),
		.out_index   (out_index),
		.out_coef    (out_coef),
		.error_count (error_count),
		.check_count (check_count),
		.pending     (pending)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic send_sample(input sample_t s);
		@(posedge clk);
		#DRIVE_DLY;
		in_valid = 1'b1;
		in_sample = s;
	endtask

	// junk on in_sample while idle
	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#DRIVE_DLY;
			in_valid = 1'b0;
			in_sample = sample_t'($urandom);
		end
	endtask

	task automatic send_block(input sample_t s [`DCT_N], input int max_gap);
		for (int i = 0; i < `DCT_N; i++) begin
			send_sample(s[i]);
			if (max_gap > 0)
				idle($urandom_range(0, max_gap));
		end
	endtask

	task automatic send_constant(input sample_t v);
		sample_t s [`DCT_N];
		foreach (s[i])
			s[i] = v;
		send_block(s, 0);
	endtask

	task automatic send_random(input int max_gap);
		sample_t s [`DCT_N];
		foreach (s[i])
			s[i] = sample_t'($urandom);
		send_block(s, max_gap);
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		in_valid = 1'b0;
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b1;
	endtask

	task automatic wait_drain();
		while (pending != 0)
			@(posedge clk);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("run timed out after %0d cycles with results still outstanding",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		int keep;
		rst = 1'b1;
		in_valid = 1'b0;
		in_sample = '0;
		void'($urandom(SEED));
		pulse_reset();
		// zero, both extremes, one random level
		send_constant('0);
		send_constant(MAX_SAMPLE);
		send_constant(MIN_SAMPLE);
		send_constant(sample_t'($urandom));
		idle(1);
		repeat (NUM_DENSE)
			send_random(0);
		repeat (NUM_GAPPY) begin
			send_random(2);
			idle($urandom_range(0, 4));
		end
		idle(1);
		wait_drain();
		// cut a block short with reset
		keep = $urandom_range(1, `DCT_N - 1);
		repeat (keep)
			send_sample(sample_t'($urandom));
		pulse_reset();
		repeat (NUM_AFTER_RST)
			send_random(0);
		idle(1);
		wait_drain();
		idle(10);
		$display("%0d of %0d coefficients checked, %0d errors", check_count, EXPECTED,
			error_count);
		if (error_count == 0 && check_count == EXPECTED)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* dct_1d_top.f */
+incdir+include
verilog/dct_types_pkg.sv
verilog/dct_ctrl_pkg.sv
verilog/dct_butterfly.sv
verilog/dct_pair_buffer.sv
verilog/dct_even_odd_mac.sv
verilog/dct_1d_top.sv
sim/dct_checker.sv
sim/tb_dct_1d.sv
